// File: hdl/spritePkg.sv
// Raster, memory-map and attribute constants; clocksPerPixel must be at least 2.
package spritePkg;

	//////////////////////////////
	// raster timing
	localparam int clocksPerPixel = 8;
	localparam int hTotal = 384;
	localparam int hActive = 256;
	localparam int vTotal = 264;

	//////////////////////////////
	// sprite and pattern memories
	localparam int spriteCount = 64;
	localparam int spriteRamDepth = 256;	// four attribute bytes per sprite.
	localparam int patternRamDepth = 8192;
	localparam int pixelWidth = 8;	// palette in the high nibble, colour in the low one.

	//////////////////////////////
	// host address map
	localparam int addrWidth = 16;
	localparam logic [addrWidth-1:0] spriteRamBase = 16'h0000;
	localparam logic [addrWidth-1:0] ctrlAddr = 16'h4000;
	localparam logic [addrWidth-1:0] patternRamBase = 16'h8000;
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	typedef enum logic [2:0] {
		waitLine,
		fetchY,
		fetchAttr,
		fetchPattern,
		fetchX,
		fetchWords,
		draw,
		nextSprite
	} engineState;

endpackage

// File: hdl/dualPortRam.sv
// Registered-read RAM; a write and a clear to the same address in one cycle keep the write.
`timescale 1ns/1ps

module dualPortRam #(
	parameter type dataType = logic [7:0],
	parameter int depth = 256
) (
	input  logic MCLK,
	input  logic we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  dataType wdata,
	input  logic re,
	input  logic [$clog2(depth)-1:0] raddr,
	input  logic clearOnRead,
	output dataType rdata
);

	dataType mem [depth];

	always_ff @(posedge MCLK) begin
		if (re) begin
			rdata <= mem[raddr];
			if (clearOnRead) begin
				mem[raddr] <= '0;	// the location is consumed by this read.
			end
		end
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

endmodule

// File: hdl/videoTiming.sv
// Raster counters for a 384 x 264 frame; hPos and vPos step only on the pixel enable.
`timescale 1ns/1ps

module videoTiming (
	input  logic MCLK,
	input  logic RESET,
	output logic pixelEn,
	output logic [8:0] hPos,
	output logic [8:0] vPos
);

	import spritePkg::*;

	logic [$clog2(clocksPerPixel)-1:0] divCount;
	logic lastPixel;

	assign lastPixel = (hPos == 9'(hTotal - 1));

	//////////////////////////////
	// pixel clock enable
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			divCount <= '0;
			pixelEn <= 1'b0;
		end else begin
			if (divCount == ($bits(divCount))'(clocksPerPixel - 1)) begin
				divCount <= '0;
			end else begin
				divCount <= divCount + 1'b1;
			end
			pixelEn <= (divCount == ($bits(divCount))'(clocksPerPixel - 1));
		end
	end

	//////////////////////////////
	// raster position
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			hPos <= '0;
			vPos <= '0;
		end else if (pixelEn) begin
			if (lastPixel) begin
				hPos <= '0;
				if (vPos == 9'(vTotal - 1)) begin
					vPos <= '0;
				end else begin
					vPos <= vPos + 9'd1;	// a new line starts with the horizontal wrap.
				end
			end else begin
				hPos <= hPos + 9'd1;
			end
		end
	end

endmodule

// File: hdl/hostRegs.sv
// AXI4-Lite slave; write address and data must arrive together, and the RAMs read back as zero.
`timescale 1ns/1ps

module hostRegs (
	input  logic MCLK,
	input  logic RESET,
	input  logic [spritePkg::addrWidth-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [spritePkg::addrWidth-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic spriteWe,
	output logic [7:0] spriteWaddr,
	output logic [7:0] spriteWdata,
	output logic patternWe,
	output logic [12:0] patternWaddr,
	output logic [31:0] patternWdata,
	output logic altLayout
);

	import spritePkg::*;

	logic writeAccept;
	logic writeMapped;

	function automatic logic inSpriteRange(input logic [addrWidth-1:0] addr);
		inSpriteRange = (addr >= spriteRamBase) && (addr < spriteRamBase + spriteRamDepth * 4);
	endfunction

	function automatic logic inPatternRange(input logic [addrWidth-1:0] addr);
		inPatternRange = (addr >= patternRamBase);	// runs to the top of the address space.
	endfunction

	assign awready = writeAccept;
	assign wready = writeAccept;
	assign writeMapped = inSpriteRange(awaddr) || inPatternRange(awaddr) || (awaddr == ctrlAddr);

	// the RAM ports write during the single cycle of the handshake.
	assign spriteWe = writeAccept && wstrb[0] && inSpriteRange(awaddr);
	assign spriteWaddr = awaddr[9:2];
	assign spriteWdata = wdata[7:0];
	assign patternWe = writeAccept && (|wstrb) && inPatternRange(awaddr);
	assign patternWaddr = awaddr[14:2];
	assign patternWdata = wdata;

	//////////////////////////////
	// write channel
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			writeAccept <= 1'b0;
			bvalid <= 1'b0;
			altLayout <= 1'b0;
		end else begin
			writeAccept <= awvalid && wvalid && !writeAccept && !bvalid;
			if (writeAccept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (writeAccept && wstrb[0] && (awaddr == ctrlAddr)) begin
				altLayout <= wdata[0];
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (writeAccept) begin
			bresp <= writeMapped ? respOkay : respSlvErr;
		end
	end

	//////////////////////////////
	// read channel
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arready) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (arready) begin
			if (araddr == ctrlAddr) begin
				rdata <= {31'd0, altLayout};
				rresp <= respOkay;
			end else if (inSpriteRange(araddr) || inPatternRange(araddr)) begin
				rdata <= '0;
				rresp <= respOkay;
			end else begin
				rdata <= '0;
				rresp <= respSlvErr;
			end
		end
	end

endmodule

// File: hdl/spriteEngine.sv
// One walk of all 64 sprites per line; RAM data must arrive exactly one cycle after its address.
`timescale 1ns/1ps

module spriteEngine (
	input  logic MCLK,
	input  logic RESET,
	input  logic altLayout,
	input  logic [8:0] hPos,
	input  logic [8:0] vPos,
	output logic [7:0] spriteAddr,
	input  logic [7:0] spriteData,
	output logic [12:0] patternAddr,
	input  logic [31:0] patternData,
	output logic writeEn,
	output logic [8:0] writeAddr,
	output logic [spritePkg::pixelWidth-1:0] writePixel
);

	import spritePkg::*;

	engineState state;
	logic [5:0] spriteNum;
	logic lineDone;
	logic [1:0] wordStep;
	logic [3:0] column;
	logic [8:0] nextLine;
	logic [7:0] targetLine;
	logic [7:0] yPos;
	logic [7:0] attrByte;
	logic [7:0] patternNum;
	logic [7:0] xPos;
	logic [3:0] palette;
	logic [3:0] lineRow;
	logic flipH;
	logic flipV;
	logic [31:0] word0;
	logic [31:0] word1;
	logic [7:0] lineDiff;
	logic disabled;
	logic yHit;
	logic xHigh;
	logic [3:0] row;
	logic [3:0] colour;

	function automatic logic [3:0] pickNibble(input logic [3:0] col, input logic [31:0] lowWord,
		input logic [31:0] highWord);
		logic [31:0] word;
		logic [7:0] pixByte;
		word = col[3] ? highWord : lowWord;
		pixByte = word[col[2:1] * 8 +: 8];
		pickNibble = col[0] ? pixByte[3:0] : pixByte[7:4];	// the left pixel sits high.
	endfunction

	assign nextLine = (vPos == 9'(vTotal - 1)) ? 9'd0 : vPos + 9'd1;
	assign lineDiff = targetLine - yPos;
	assign disabled = altLayout ? spriteData[3] : spriteData[7];
	assign yHit = (lineDiff[7:4] == 4'hf) && !disabled;
	assign xHigh = !altLayout && attrByte[6];
	assign row = lineRow ^ {4{flipV}};
	assign colour = pickNibble(column, word0, word1);

	// the byte index runs one state ahead of the data it brings back.
	always_comb begin
		case (state)
			fetchY: spriteAddr = {spriteNum, 2'd1};
			fetchAttr: spriteAddr = {spriteNum, 2'd2};
			fetchPattern: spriteAddr = {spriteNum, 2'd3};
			nextSprite: spriteAddr = {spriteNum + 6'd1, 2'd0};
			default: spriteAddr = {spriteNum, 2'd0};
		endcase
	end

	assign writeEn = (state == draw) && (colour != 4'd0);
	assign writeAddr = {1'b0, xPos} - {xHigh, 8'h00} + {5'd0, column ^ {4{flipH}}} - 9'd1;
	assign writePixel = {palette, colour};

	//////////////////////////////
	// walk control
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			state <= waitLine;
			spriteNum <= '0;
			lineDone <= 1'b0;
			wordStep <= '0;
			column <= '0;
		end else begin
			case (state)
				waitLine: begin
					if (hPos >= 9'(hActive)) begin
						lineDone <= 1'b0;
					end else if (!lineDone) begin
						state <= fetchY;
					end
				end
				fetchY: state <= fetchAttr;
				fetchAttr: state <= yHit ? fetchPattern : nextSprite;
				fetchPattern: state <= fetchX;
				fetchX: begin
					wordStep <= '0;
					state <= fetchWords;
				end
				fetchWords: begin
					wordStep <= wordStep + 2'd1;
					if (wordStep == 2'd2) begin
						column <= '0;
						state <= draw;
					end
				end
				draw: begin
					column <= column + 4'd1;
					if (column == 4'd15) begin
						state <= nextSprite;
					end
				end
				default: begin
					spriteNum <= spriteNum + 6'd1;
					if (spriteNum == 6'(spriteCount - 1)) begin
						lineDone <= 1'b1;
						state <= waitLine;
					end else begin
						state <= fetchY;
					end
				end
			endcase
		end
	end

	//////////////////////////////
	// attribute and pattern capture
	always_ff @(posedge MCLK) begin
		case (state)
			waitLine: targetLine <= nextLine[7:0];
			fetchY: yPos <= spriteData;
			fetchAttr: begin
				attrByte <= spriteData;
				lineRow <= lineDiff[3:0];
				if (altLayout) begin
					palette <= spriteData[7:4];
				end else begin
					palette <= spriteData[3:0];
					flipH <= spriteData[4];
					flipV <= spriteData[5];
				end
			end
			fetchPattern: begin
				if (altLayout) begin
					flipH <= spriteData[0];
					flipV <= spriteData[1];
					patternNum <= {attrByte[1:0], spriteData[7:2]};	// bit 8 is not stored.
				end else begin
					patternNum <= spriteData;
				end
			end
			fetchX: begin
				xPos <= spriteData;
				patternAddr <= {patternNum, row[3], 1'b0, row[2:0]};
			end
			fetchWords: begin
				case (wordStep)
					2'd0: patternAddr[3] <= 1'b1;	// second half of the row.
					2'd1: word0 <= patternData;
					default: word1 <= patternData;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: hdl/lineBuffer.sv
// Two 512-pixel banks; pixelOut trails hPos by one pixel and shows no blanking.
`timescale 1ns/1ps

module lineBuffer (
	input  logic MCLK,
	input  logic pixelEn,
	input  logic [8:0] hPos,
	input  logic [8:0] vPos,
	input  logic writeEn,
	input  logic [8:0] writeAddr,
	input  logic [spritePkg::pixelWidth-1:0] writePixel,
	output logic [3:0] pixelOut
);

	import spritePkg::*;

	logic readStrobe;
	logic [pixelWidth-1:0] storedPixel;
	logic [3:0] storedPalette;
	logic [3:0] storedColour;

	// the engine fills one bank while the other is shown.
	dualPortRam #(
		.dataType(logic [pixelWidth-1:0]),
		.depth(1024)
	) u_pixelRam (
		.MCLK(MCLK),
		.we(writeEn),
		.waddr({vPos[0], writeAddr}),
		.wdata(writePixel),
		.re(readStrobe),
		.raddr({~vPos[0], hPos}),
		.clearOnRead(1'b1),
		.rdata(storedPixel)
	);

	// read once, just after the raster position has moved.
	always_ff @(posedge MCLK) begin
		readStrobe <= pixelEn;
	end

	assign storedPalette = storedPixel[pixelWidth-1 -: 4];
	assign storedColour = storedPixel[3:0];

	//////////////////////////////
	// output pixel
	always_ff @(posedge MCLK) begin
		if (pixelEn) begin
			if (storedColour == 4'd1) begin
				pixelOut <= storedPalette;	// colour 1 shows the palette number.
			end else begin
				pixelOut <= storedColour;
			end
		end
	end

endmodule

// File: hdl/spriteSubsystem.sv
// Sprite generator top; host memories are write-only and only the control bit reads back.
`timescale 1ns/1ps

module spriteSubsystem (
	input  logic MCLK,
	input  logic RESET,
	input  logic [spritePkg::addrWidth-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [spritePkg::addrWidth-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [8:0] hPos,
	output logic [8:0] vPos,
	output logic [3:0] pixelOut
);

	import spritePkg::*;

	logic pixelEn;
	logic altLayout;
	logic spriteWe;
	logic [7:0] spriteWaddr;
	logic [7:0] spriteWdata;
	logic patternWe;
	logic [12:0] patternWaddr;
	logic [31:0] patternWdata;
	logic [7:0] spriteAddr;
	logic [7:0] spriteData;
	logic [12:0] patternAddr;
	logic [31:0] patternData;
	logic writeEn;
	logic [8:0] writeAddr;
	logic [pixelWidth-1:0] writePixel;

	videoTiming u_videoTiming (.MCLK, .RESET, .pixelEn, .hPos, .vPos);

	hostRegs u_hostRegs (
		.MCLK, .RESET,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.spriteWe, .spriteWaddr, .spriteWdata,
		.patternWe, .patternWaddr, .patternWdata, .altLayout
	);

	//////////////////////////////
	// sprite attribute and pattern memories
	dualPortRam #(.dataType(logic [7:0]), .depth(spriteRamDepth)) u_spriteRam (
		.MCLK, .we(spriteWe), .waddr(spriteWaddr), .wdata(spriteWdata),
		.re(1'b1), .raddr(spriteAddr), .clearOnRead(1'b0), .rdata(spriteData)
	);

	dualPortRam #(.dataType(logic [31:0]), .depth(patternRamDepth)) u_patternRam (
		.MCLK, .we(patternWe), .waddr(patternWaddr), .wdata(patternWdata),
		.re(1'b1), .raddr(patternAddr), .clearOnRead(1'b0), .rdata(patternData)
	);

	spriteEngine u_spriteEngine (
		.MCLK, .RESET, .altLayout, .hPos, .vPos,
		.spriteAddr, .spriteData, .patternAddr, .patternData,
		.writeEn, .writeAddr, .writePixel
	);

	lineBuffer u_lineBuffer (
		.MCLK, .pixelEn, .hPos, .vPos,
		.writeEn, .writeAddr, .writePixel, .pixelOut
	);

endmodule

// File: bench/spriteSubsystemTb.sv
// Run from the project root; one frame is about 8.1 ms of simulated time and a run needs two.
`timescale 1ns/1ps

module spriteSubsystemTb;

	import spritePkg::*;

	localparam int busLimit = 32;	// cycles allowed for one AXI handshake step.
	localparam int rasterLimit = 1700000;	// a little over two frames.

	logic MCLK;
	logic RESET;
	logic [addrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [addrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [8:0] hPos;
	logic [8:0] vPos;
	logic [3:0] pixelOut;

	int checkCount;
	int errorCount;
	int testCount;
	int testErrors;

	spriteSubsystem u_spriteSubsystem (.*);

	initial begin
		MCLK = 1'b0;
		forever begin
			#5 MCLK = ~MCLK;
		end
	end

	//////////////////////////////
	// reporting
	task automatic abortRun(input string reason);
		$display("%0s", reason);
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic compareValue(input string signal, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("ERR %0s expected %h got %h", signal, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportBadLine(input string text);
		$display("malformed vector line: %0s", text);
		errorCount++;
	endtask

	//////////////////////////////
	// AXI4-Lite master
	task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int count;
		awaddr = addr[addrWidth-1:0];
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		count = 0;
		while (!(awready && wready)) begin
			@(posedge MCLK);
			#1;
			count++;
			if (count > busLimit) begin
				abortRun($sformatf("write to %h was never accepted", addr[15:0]));
			end
		end
		@(posedge MCLK);	// handshake edge.
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		count = 0;
		while (!bvalid) begin
			@(posedge MCLK);
			#1;
			count++;
			if (count > busLimit) begin
				abortRun($sformatf("no write response for %h", addr[15:0]));
			end
		end
		resp = bresp;
		@(posedge MCLK);
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int count;
		araddr = addr[addrWidth-1:0];
		arvalid = 1'b1;
		count = 0;
		while (!arready) begin
			@(posedge MCLK);
			#1;
			count++;
			if (count > busLimit) begin
				abortRun($sformatf("read of %h was never accepted", addr[15:0]));
			end
		end
		@(posedge MCLK);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		count = 0;
		while (!rvalid) begin
			@(posedge MCLK);
			#1;
			count++;
			if (count > busLimit) begin
				abortRun($sformatf("no read data for %h", addr[15:0]));
			end
		end
		data = rdata;
		resp = rresp;
		@(posedge MCLK);
		#1;
		rready = 1'b0;
	endtask

	// byte1 = 0x88 carries the disable bit of both attribute layouts.
	task automatic disableAllSprites();
		logic [1:0] resp;
		for (int n = 0; n < spriteCount; n++) begin
			axiWrite(32'(n * 16 + 4), 32'h88, resp);
			compareValue("bresp during sprite clear", 32'h0, {30'd0, resp});
		end
	endtask

	task automatic waitPixel(input int line, input int x);
		int count;
		count = 0;
		while (!(vPos == 9'(line) && hPos == 9'(x + 1))) begin
			@(posedge MCLK);
			#1;
			count++;
			if (count > rasterLimit) begin
				abortRun($sformatf("raster never reached line %0d pixel %0d", line, x));
			end
		end
	endtask

	//////////////////////////////
	// vector interpreter
	initial begin
		int fd;
		int fields;
		string lineBuf;
		string testName;
		logic [7:0] cmd;
		logic [31:0] fieldA;
		logic [31:0] fieldB;
		logic [31:0] fieldC;
		logic [31:0] readData;
		logic [1:0] resp;
		RESET = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		testErrors = 0;
		repeat (3) @(posedge MCLK);
		#1;
		compareValue("hPos after reset", 32'h0, {23'd0, hPos});
		compareValue("vPos after reset", 32'h0, {23'd0, vPos});
		RESET = 1'b0;
		disableAllSprites();
		fd = $fopen("bench/spriteVectors.txt", "r");
		if (fd == 0) begin
			abortRun("cannot open bench/spriteVectors.txt");
		end
		while (!$feof(fd)) begin
			lineBuf = "";
			fields = $fgets(lineBuf, fd);
			cmd = (lineBuf.len() > 0) ? lineBuf[0] : 8'h0a;
			case (cmd)
				"W": begin
					fields = $sscanf(lineBuf, "W %h %h %h", fieldA, fieldB, fieldC);
					if (fields != 3) begin
						reportBadLine(lineBuf);
					end else begin
						axiWrite(fieldA, fieldB, resp);
						compareValue($sformatf("bresp at %h", fieldA[15:0]), fieldC,
							{30'd0, resp});
					end
				end
				"R": begin
					fields = $sscanf(lineBuf, "R %h %h %h", fieldA, fieldB, fieldC);
					if (fields != 3) begin
						reportBadLine(lineBuf);
					end else begin
						axiRead(fieldA, readData, resp);
						compareValue($sformatf("rdata at %h", fieldA[15:0]), fieldB, readData);
						compareValue($sformatf("rresp at %h", fieldA[15:0]), fieldC,
							{30'd0, resp});
					end
				end
				"P": begin
					fields = $sscanf(lineBuf, "P %d %d %h", fieldA, fieldB, fieldC);
					if (fields != 3) begin
						reportBadLine(lineBuf);
					end else begin
						waitPixel(fieldA, fieldB);
						compareValue($sformatf("pixelOut line %0d x %0d", fieldA, fieldB),
							fieldC, {28'd0, pixelOut});
					end
				end
				"T": begin
					fields = $sscanf(lineBuf, "T %s", testName);
					if (fields != 1) begin
						reportBadLine(lineBuf);
					end else begin
						testCount++;
						if (errorCount == testErrors) begin
							$display("test %0s: ok", testName);
						end else begin
							$display("test %0s: failed, %0d errors", testName,
								errorCount - testErrors);
						end
						testErrors = errorCount;
					end
				end
				"#", "\n", "\r", " ": ;	// comments and blank lines.
				default: begin
					$display("unknown vector command in line: %0s", lineBuf);
					errorCount++;
				end
			endcase
		end
		$fclose(fd);
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: spriteSubsystem.f
hdl/spritePkg.sv
hdl/dualPortRam.sv
hdl/videoTiming.sv
hdl/hostRegs.sv
hdl/spriteEngine.sv
hdl/lineBuffer.sv
hdl/spriteSubsystem.sv
bench/spriteSubsystemTb.sv

// File: bench/spriteVectors.txt
# W addr data bresp | R addr rdata rresp (all hex) | P line x pixel (line, x decimal; pixel hex)
# T name closes a test; pattern 1 row 0 holds colours 0..f, row 15 holds 2 then 3.
W 4000 00000001 0
R 4000 00000001 0
W 4000 00000000 0
R 4000 00000000 0
W 2000 0000005A 2
R 2000 00000000 2
R 0010 00000000 0
R 8100 00000000 0
T regDecode
W 8080 67452301 0
W 80A0 EFCDAB89 0
W 80DC 22222222 0
W 80FC 33333333 0
W 0000 00000030 0
W 0004 00000009 0
W 0008 00000001 0
W 000C 00000020 0
P 32 31 0
P 32 32 9
P 32 46 f
P 32 47 0
P 47 31 2
P 47 39 3
T standardSprite
W 0010 00000060 0
W 0014 00000076 0
W 0018 00000001 0
W 001C 000000FA 0
P 80 0 3
P 80 8 2
P 80 9 0
P 95 0 8
P 95 7 6
P 95 8 0
T flipsAndXHigh
W 0020 00000090 0
W 0024 00000001 0
W 0028 00000001 0
W 002C 00000080 0
W 0030 00000090 0
W 0034 00000002 0
W 0038 00000001 0
W 003C 00000084 0
W 0040 00000090 0
W 0044 00000085 0
W 0048 00000001 0
W 004C 000000B0 0
P 128 130 3
P 128 131 4
P 128 132 2
P 128 146 f
P 128 180 0
T overlapDisable
W 4000 00000001 0
W 0050 000000C0 0
W 0054 00000060 0
W 0058 00000007 0
W 005C 00000040 0
P 176 63 3
P 176 78 2
P 191 63 f
P 191 77 6
P 191 78 0
T altLayout
W 0054 00000068 0
P 176 63 0
P 191 77 0
T clearOnRead
